// ==== psram_cache_pkg.sv ====
// ****************************************************************************
// psram cache package
// cache geometry, burst RAM timing and the enums shared by the cache RTL
// ****************************************************************************
`default_nettype none

package psram_cache_pkg;

  // byte address split as |tag|line|column|00|
  localparam int LINE_IX_BITS = 8;
  localparam int COLUMN_IX_BITS = 3;
  localparam int ZERO_BITS = 2;
  localparam int COLUMN_COUNT = 2 ** COLUMN_IX_BITS;
  localparam int LINE_OFFSET_BITS = COLUMN_IX_BITS + ZERO_BITS;
  localparam int TAG_BITS = 32 - LINE_IX_BITS - LINE_OFFSET_BITS;

  // flags sit directly above the tag in the 32-bit tag word
  localparam int LINE_VALID_BIT = TAG_BITS;
  localparam int LINE_DIRTY_BIT = TAG_BITS + 1;

  // burst RAM is byte addressed with 64-bit words
  localparam int RAM_DEPTH_BITS = 16;
  localparam int RAM_WORD_BITS = RAM_DEPTH_BITS - 3;
  // tag bits that still reach the RAM address, the rest alias
  localparam int RAM_TAG_BITS = RAM_DEPTH_BITS - LINE_IX_BITS - LINE_OFFSET_BITS;

  // one less than the PSRAM spec since the counter starts a cycle late
  localparam int COMMAND_DELAY = 13;
  localparam int READ_LATENCY = 6;
  localparam int BURST_BEATS = 4;

  localparam int GAP_BITS = $clog2(COMMAND_DELAY + 1);
  localparam int BEAT_BITS = $clog2(BURST_BEATS);
  localparam int LAT_BITS = $clog2(READ_LATENCY);
  localparam logic [GAP_BITS-1:0] GAP_LOAD = GAP_BITS'(COMMAND_DELAY);
  // first beat is fetched two cycles before it shows up as valid
  localparam logic [LAT_BITS-1:0] LAT_LOAD = LAT_BITS'(READ_LATENCY - 2);

  // one-hot controller states
  typedef enum logic [10:0] {
    idle            = 11'b000_0000_0001,
    read_wait       = 11'b000_0000_0010,
    read_1          = 11'b000_0000_0100,
    read_2          = 11'b000_0000_1000,
    read_3          = 11'b000_0001_0000,
    read_update_tag = 11'b000_0010_0000,
    read_finish     = 11'b000_0100_0000,
    write_1         = 11'b000_1000_0000,
    write_2         = 11'b001_0000_0000,
    write_3         = 11'b010_0000_0000,
    write_finish    = 11'b100_0000_0000
  } cache_state_e;

  typedef enum logic {
    br_read  = 1'b0,
    br_write = 1'b1
  } br_cmd_e;

endpackage

`default_nettype wire

// ==== byte_ram.sv ====
// ****************************************************************************
// byte_ram
// byte-enabled simple dual-port block RAM, one 32-bit word per cache line,
// registered read, contents start at zero
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module byte_ram (
  input  wire                                    clk,
  input  wire  [3:0]                             write_enable,
  input  wire  [psram_cache_pkg::LINE_IX_BITS-1:0] address,
  input  wire  [31:0]                            data_in,
  output logic [31:0]                            data_out
);

  logic [31:0] mem [2 ** psram_cache_pkg::LINE_IX_BITS];

  // block RAM power-up contents, so all valid flags start clear
  initial begin
    for (int i = 0; i < 2 ** psram_cache_pkg::LINE_IX_BITS; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
      end
    end
    // read returns the old word when writing the same address
    data_out <= mem[address];
  end

endmodule

`default_nettype wire

// ==== cache.sv ====
// ****************************************************************************
// cache
// direct-mapped write-back data cache in front of a PSRAM style burst RAM,
// hit path, dirty line eviction and line fill
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module cache (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        enable,
  input  wire  [31:0]                                address,
  input  wire  [31:0]                                data_in,
  input  wire  [3:0]                                 write_enable,
  output logic [31:0]                                data_out,
  output logic                                       data_out_ready,
  output logic                                       busy,
  output psram_cache_pkg::br_cmd_e                   br_cmd,
  output logic                                       br_cmd_en,
  output logic [psram_cache_pkg::RAM_DEPTH_BITS-1:0] br_addr,
  output logic [63:0]                                br_wr_data,
  input  wire  [63:0]                                br_rd_data,
  input  wire                                        br_rd_data_valid
);

  logic [psram_cache_pkg::COLUMN_IX_BITS-1:0] column_ix;
  logic [psram_cache_pkg::LINE_IX_BITS-1:0]   line_ix;
  logic [psram_cache_pkg::TAG_BITS-1:0]       address_tag;
  logic [psram_cache_pkg::LINE_IX_BITS-1:0]   looked_up_line;

  logic [31:0] tag_word;
  logic [31:0] tag_din;
  logic [3:0]  tag_we;
  logic        line_valid;
  logic        line_dirty;
  logic [psram_cache_pkg::TAG_BITS-1:0] cached_tag;
  logic        hit;
  logic        write_hit;

  logic [31:0] column_data_out [psram_cache_pkg::COLUMN_COUNT];
  logic [31:0] column_din      [psram_cache_pkg::COLUMN_COUNT];
  logic [3:0]  column_we       [psram_cache_pkg::COLUMN_COUNT];

  psram_cache_pkg::cache_state_e state;
  logic [psram_cache_pkg::GAP_BITS-1:0]  gap_cnt;
  logic                                  fill_en;
  logic [psram_cache_pkg::BEAT_BITS-1:0] fill_beat;

  logic [psram_cache_pkg::RAM_DEPTH_BITS-1:0] fill_addr;
  logic [psram_cache_pkg::RAM_DEPTH_BITS-1:0] evict_addr;

  // |tag|line|column|00|
  assign column_ix = address[psram_cache_pkg::LINE_OFFSET_BITS-1 -: psram_cache_pkg::COLUMN_IX_BITS];
  assign line_ix = address[psram_cache_pkg::LINE_OFFSET_BITS +: psram_cache_pkg::LINE_IX_BITS];
  assign address_tag = address[31 -: psram_cache_pkg::TAG_BITS];

  byte_ram u_tag_ram (
    .clk          (clk),
    .write_enable (tag_we),
    .address      (line_ix),
    .data_in      (tag_din),
    .data_out     (tag_word)
  );

  for (genvar i = 0; i < psram_cache_pkg::COLUMN_COUNT; i++) begin : g_column
    byte_ram u_column_ram (
      .clk          (clk),
      .write_enable (column_we[i]),
      .address      (line_ix),
      .data_in      (column_din[i]),
      .data_out     (column_data_out[i])
    );
  end

  assign line_valid = tag_word[psram_cache_pkg::LINE_VALID_BIT];
  assign line_dirty = tag_word[psram_cache_pkg::LINE_DIRTY_BIT];
  assign cached_tag = tag_word[psram_cache_pkg::TAG_BITS-1:0];

  // RAM outputs only belong to the current line once it has been read
  assign hit = looked_up_line == line_ix && line_valid && cached_tag == address_tag;
  assign write_hit = state == psram_cache_pkg::idle && enable && hit && write_enable != 4'b0000;

  assign busy = enable && !hit || gap_cnt != 0;
  assign data_out = column_data_out[column_ix];
  assign data_out_ready = enable && hit && write_enable == 4'b0000;

  assign fill_addr = {address[psram_cache_pkg::RAM_DEPTH_BITS-1:psram_cache_pkg::LINE_OFFSET_BITS],
                      {psram_cache_pkg::LINE_OFFSET_BITS{1'b0}}};
  assign evict_addr = {cached_tag[psram_cache_pkg::RAM_TAG_BITS-1:0], line_ix,
                       {psram_cache_pkg::LINE_OFFSET_BITS{1'b0}}};

  // which beat of the fill burst is on br_rd_data
  always_comb begin
    fill_en = 1'b0;
    fill_beat = '0;
    case (state)
      psram_cache_pkg::read_wait: fill_en = br_rd_data_valid;
      psram_cache_pkg::read_1: begin
        fill_en = 1'b1;
        fill_beat = 2'd1;
      end
      psram_cache_pkg::read_2: begin
        fill_en = 1'b1;
        fill_beat = 2'd2;
      end
      psram_cache_pkg::read_3: begin
        fill_en = 1'b1;
        fill_beat = 2'd3;
      end
      default: fill_en = 1'b0;
    endcase
  end

  // fill writes a column pair per beat, a hit write goes to one column
  always_comb begin
    for (int i = 0; i < psram_cache_pkg::COLUMN_COUNT; i++) begin
      if (fill_en) begin
        column_din[i] = (i % 2 == 0) ? br_rd_data[31:0] : br_rd_data[63:32];
        column_we[i] = (int'(fill_beat) == i / 2) ? 4'b1111 : 4'b0000;
      end else begin
        column_din[i] = data_in;
        column_we[i] = (write_hit && int'(column_ix) == i) ? write_enable : 4'b0000;
      end
    end
  end

  // tag word is {dirty, valid, tag}, dirty only set by a hit write
  always_comb begin
    tag_din = '0;
    tag_din[psram_cache_pkg::TAG_BITS-1:0] = address_tag;
    tag_din[psram_cache_pkg::LINE_VALID_BIT] = 1'b1;
    tag_din[psram_cache_pkg::LINE_DIRTY_BIT] = write_hit;
    tag_we = (write_hit || state == psram_cache_pkg::read_update_tag) ? 4'b1111 : 4'b0000;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= psram_cache_pkg::idle;
      br_cmd_en <= 1'b0;
      gap_cnt <= '0;
      looked_up_line <= '0;
    end else begin
      looked_up_line <= line_ix;
      br_cmd_en <= 1'b0;
      if (gap_cnt != 0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      unique case (state)
        psram_cache_pkg::idle: begin
          if (enable && looked_up_line == line_ix && !hit && gap_cnt == 0) begin
            br_cmd_en <= 1'b1;
            gap_cnt <= psram_cache_pkg::GAP_LOAD;
            // dirty line goes out first, the fill follows after the gap
            state <= line_dirty ? psram_cache_pkg::write_1 : psram_cache_pkg::read_wait;
          end
        end
        psram_cache_pkg::read_wait: begin
          if (br_rd_data_valid) begin
            state <= psram_cache_pkg::read_1;
          end
        end
        psram_cache_pkg::read_1: state <= psram_cache_pkg::read_2;
        psram_cache_pkg::read_2: state <= psram_cache_pkg::read_3;
        psram_cache_pkg::read_3: state <= psram_cache_pkg::read_update_tag;
        psram_cache_pkg::read_update_tag: state <= psram_cache_pkg::read_finish;
        // lets the new tag come through the registered read
        psram_cache_pkg::read_finish: state <= psram_cache_pkg::idle;
        psram_cache_pkg::write_1: state <= psram_cache_pkg::write_2;
        psram_cache_pkg::write_2: state <= psram_cache_pkg::write_3;
        psram_cache_pkg::write_3: state <= psram_cache_pkg::write_finish;
        psram_cache_pkg::write_finish: begin
          if (gap_cnt == 0) begin
            br_cmd_en <= 1'b1;
            gap_cnt <= psram_cache_pkg::GAP_LOAD;
            state <= psram_cache_pkg::read_wait;
          end
        end
        default: state <= psram_cache_pkg::idle;
      endcase
    end
  end

  // command payload, only sampled by the RAM while br_cmd_en is high
  always_ff @(posedge clk) begin
    case (state)
      psram_cache_pkg::idle: begin
        br_cmd <= line_dirty ? psram_cache_pkg::br_write : psram_cache_pkg::br_read;
        br_addr <= line_dirty ? evict_addr : fill_addr;
        br_wr_data <= {column_data_out[1], column_data_out[0]};
      end
      psram_cache_pkg::write_1: br_wr_data <= {column_data_out[3], column_data_out[2]};
      psram_cache_pkg::write_2: br_wr_data <= {column_data_out[5], column_data_out[4]};
      psram_cache_pkg::write_3: br_wr_data <= {column_data_out[7], column_data_out[6]};
      psram_cache_pkg::write_finish: begin
        br_cmd <= psram_cache_pkg::br_read;
        br_addr <= fill_addr;
      end
      default: br_addr <= br_addr;
    endcase
  end

endmodule

`default_nettype wire

// ==== burst_ram.sv ====
// ****************************************************************************
// burst_ram
// block memory model of the PSRAM IP user port: 64-bit beats, bursts of
// four, fixed read latency, one command at a time
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module burst_ram (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire psram_cache_pkg::br_cmd_e              br_cmd,
  input  wire                                        br_cmd_en,
  input  wire  [psram_cache_pkg::RAM_DEPTH_BITS-1:0] br_addr,
  input  wire  [63:0]                                br_wr_data,
  output logic [63:0]                                br_rd_data,
  output logic                                       br_rd_data_valid
);

  logic [63:0] mem [2 ** psram_cache_pkg::RAM_WORD_BITS];

  logic                                  active;
  psram_cache_pkg::br_cmd_e              op;
  logic [psram_cache_pkg::BEAT_BITS-1:0] beat;
  logic [psram_cache_pkg::LAT_BITS-1:0]  wait_cnt;
  logic [psram_cache_pkg::RAM_WORD_BITS-psram_cache_pkg::BEAT_BITS-1:0] line_addr;

  logic                                     accept;
  logic                                     wr_en;
  logic                                     rd_en;
  logic [psram_cache_pkg::RAM_WORD_BITS-1:0] word_addr;

  initial begin
    for (int i = 0; i < 2 ** psram_cache_pkg::RAM_WORD_BITS; i++) begin
      mem[i] = '0;
    end
  end

  assign accept = br_cmd_en && !active;
  // beat 0 of a write is stored in the command cycle itself
  assign wr_en = accept ? br_cmd == psram_cache_pkg::br_write
                        : active && op == psram_cache_pkg::br_write;
  assign rd_en = active && op == psram_cache_pkg::br_read && wait_cnt == 0;
  assign word_addr = accept ? {br_addr[psram_cache_pkg::RAM_DEPTH_BITS-1 -:
                                       psram_cache_pkg::RAM_WORD_BITS - psram_cache_pkg::BEAT_BITS],
                               beat}
                            : {line_addr, beat};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      op <= psram_cache_pkg::br_read;
      beat <= '0;
      wait_cnt <= '0;
      br_rd_data_valid <= 1'b0;
    end else begin
      br_rd_data_valid <= rd_en;
      if (accept) begin
        active <= 1'b1;
        op <= br_cmd;
        wait_cnt <= psram_cache_pkg::LAT_LOAD;
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      // beat wraps back to zero on the last one
      if (wr_en || rd_en) begin
        beat <= beat + 1'b1;
        if (active && &beat) begin
          active <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (accept) begin
      line_addr <= br_addr[psram_cache_pkg::RAM_DEPTH_BITS-1 -:
                           psram_cache_pkg::RAM_WORD_BITS - psram_cache_pkg::BEAT_BITS];
    end
    if (wr_en) begin
      mem[word_addr] <= br_wr_data;
    end
    br_rd_data <= mem[word_addr];
  end

endmodule

`default_nettype wire

// ==== psram_cache_top.sv ====
// ****************************************************************************
// psram_cache_top
// data cache joined to the emulated PSRAM burst memory
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module psram_cache_top (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         enable,
  input  wire  [31:0] address,
  input  wire  [31:0] data_in,
  input  wire  [3:0]  write_enable,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy
);

  // burst port between cache and memory
  psram_cache_pkg::br_cmd_e                   br_cmd;
  logic                                       br_cmd_en;
  logic [psram_cache_pkg::RAM_DEPTH_BITS-1:0] br_addr;
  logic [63:0]                                br_wr_data;
  logic [63:0]                                br_rd_data;
  logic                                       br_rd_data_valid;

  cache u_cache (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable           (enable),
    .address          (address),
    .data_in          (data_in),
    .write_enable     (write_enable),
    .data_out         (data_out),
    .data_out_ready   (data_out_ready),
    .busy             (busy),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram u_burst_ram (
    .clk              (clk),
    .rst_n            (rst_n),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

endmodule

`default_nettype wire

// ==== tb_psram_cache.sv ====
// ****************************************************************************
// tb_psram_cache
// directed testbench for the PSRAM data cache, predicts reads from a
// shadow memory and checks hits, fills, byte writes and evictions
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_psram_cache;

  // cycles a single access may take before it counts as stuck
  localparam int WAIT_LIMIT = 100;
  // about 340 accesses, a dirty miss needs under 50 cycles of 8 ns
  localparam int WATCHDOG_NS = 200_000;
  localparam int RANDOM_ACCESSES = 300;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;

  // word image of the low 64 KB
  logic [31:0] shadow [16384];
  logic [31:0] lfsr_state = 32'hf6bf2b27;
  int          errors = 0;
  int          checks = 0;

  psram_cache_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .address        (address),
    .data_in        (data_in),
    .write_enable   (write_enable),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, one step per bit returned
  function logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  task automatic merge_shadow(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        shadow[addr[15:2]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic read_check(input string name, input logic [31:0] addr, output int cycles);
    logic [31:0] expected;
    @(posedge clk);
    enable <= 1'b1;
    address <= addr;
    write_enable <= 4'b0000;
    cycles = 0;
    @(negedge clk);
    while (!data_out_ready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    if (!data_out_ready) begin
      $display("%s: read of %h got no data_out_ready within %0d cycles", name, addr, WAIT_LIMIT);
      errors++;
    end else begin
      expected = shadow[addr[15:2]];
      if (data_out !== expected) begin
        $display("MISMATCH %s: address %h expected %h actual %h", name, addr, expected,
                 data_out);
        errors++;
      end
    end
  endtask

  task automatic write_word(input string name, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask);
    int cycles;
    @(posedge clk);
    enable <= 1'b1;
    address <= addr;
    data_in <= data;
    write_enable <= mask;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("%s: write to %h still busy after %0d cycles", name, addr, WAIT_LIMIT);
      errors++;
    end
    // the write lands on this edge
    @(posedge clk);
    merge_shadow(addr, data, mask);
  endtask

  task automatic idle_quiet(input string name);
    int cycles;
    @(posedge clk);
    enable <= 1'b0;
    write_enable <= 4'b0000;
    cycles = 0;
    @(negedge clk);
    // the command gap of the last miss may still be counting down
    while (busy && cycles < WAIT_LIMIT) begin
      if (data_out_ready) begin
        $display("%s: data_out_ready high while enable is low", name);
        errors++;
      end
      @(negedge clk);
      cycles++;
    end
    for (int i = 0; i < 10; i++) begin
      checks++;
      if (busy || data_out_ready) begin
        $display("%s: busy or data_out_ready high while enable is low", name);
        errors++;
      end
      @(negedge clk);
    end
  endtask

  task automatic cold_reads();
    int cycles;
    read_check("cold_reads", 32'h0000_0100, cycles);
    read_check("cold_reads", 32'h0000_0104, cycles);
    checks++;
    if (cycles > 1) begin
      $display("cold_reads: read in a filled line took %0d cycles, not a hit", cycles);
      errors++;
    end
    read_check("cold_reads", 32'h0000_3f20, cycles);
    read_check("cold_reads", 32'h0000_8a7c, cycles);
    read_check("cold_reads", 32'h0000_8a60, cycles);
  endtask

  task automatic word_write_read();
    int cycles;
    write_word("word_write_read", 32'h0000_5550, 32'hc0de_5a17, 4'b1111);
    read_check("word_write_read", 32'h0000_5550, cycles);
    write_word("word_write_read", 32'h0000_5554, random_bits(32), 4'b1111);
    read_check("word_write_read", 32'h0000_5554, cycles);
    read_check("word_write_read", 32'h0000_5550, cycles);
  endtask

  task automatic byte_mask_merge();
    int cycles;
    logic [3:0] mask;
    write_word("byte_mask_merge", 32'h0000_2468, 32'h1122_3344, 4'b1111);
    read_check("byte_mask_merge", 32'h0000_2468, cycles);
    // every non-zero mask, single bytes and mixes
    for (int m = 1; m < 16; m++) begin
      mask = 4'(m);
      write_word("byte_mask_merge", 32'h0000_2468, random_bits(32), mask);
      read_check("byte_mask_merge", 32'h0000_2468, cycles);
    end
  endtask

  task automatic dirty_eviction();
    int cycles;
    // same line index 0x52, tags differ
    write_word("dirty_eviction", 32'h0000_0a40, 32'ha5a5_0001, 4'b1111);
    write_word("dirty_eviction", 32'h0000_0a5c, 32'ha5a5_0007, 4'b1111);
    write_word("dirty_eviction", 32'h0000_2a40, 32'h5a5a_1001, 4'b1111);
    read_check("dirty_eviction", 32'h0000_0a40, cycles);
    read_check("dirty_eviction", 32'h0000_0a5c, cycles);
    read_check("dirty_eviction", 32'h0000_2a40, cycles);
    write_word("dirty_eviction", 32'h0000_6a44, 32'h0f0f_6004, 4'b0011);
    read_check("dirty_eviction", 32'h0000_2a40, cycles);
    read_check("dirty_eviction", 32'h0000_6a44, cycles);
  endtask

  task automatic random_mix();
    int          cycles;
    logic [31:0] sel;
    logic [31:0] tag;
    logic [31:0] col;
    logic [31:0] line;
    logic [31:0] op;
    logic [31:0] mask_bits;
    logic [31:0] addr;
    for (int n = 0; n < RANDOM_ACCESSES; n++) begin
      sel = random_bits(2);
      case (sel)
        32'd0:   line = 32'h03;
        32'd1:   line = 32'h47;
        32'd2:   line = 32'h90;
        default: line = 32'hfe;
      endcase
      tag = random_bits(3);
      col = random_bits(3);
      addr = (tag << 13) | (line << 5) | (col << 2);
      op = random_bits(1);
      mask_bits = random_bits(4);
      if (op[0] && mask_bits[3:0] != 4'b0000) begin
        write_word("random_mix", addr, random_bits(32), mask_bits[3:0]);
      end else begin
        read_check("random_mix", addr, cycles);
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = 4'b0000;
    for (int i = 0; i < 16384; i++) begin
      shadow[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    idle_quiet("after_reset");
    cold_reads();
    idle_quiet("after_cold_reads");
    word_write_read();
    idle_quiet("after_word_write_read");
    byte_mask_merge();
    idle_quiet("after_byte_mask_merge");
    dirty_eviction();
    idle_quiet("after_dirty_eviction");
    random_mix();
    idle_quiet("after_random_mix");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== psram_cache.f ====
psram_cache_pkg.sv
byte_ram.sv
cache.sv
burst_ram.sv
psram_cache_top.sv
tb_psram_cache.sv

// ==== Makefile ====
# Verilator build and run of the PSRAM cache testbench

VERILATOR ?= verilator
TOP       ?= tb_psram_cache
FILELIST  ?= psram_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
